//--- source/feed_config.svh
`ifndef FEED_CONFIG_SVH
`define FEED_CONFIG_SVH

// datapath widths
`define FEED_DATA_W      128
`define FEED_ADDR_W      14
`define FEED_ROM_DEPTH   8384
`define FEED_CODE_W      4
`define FEED_COUNT_W     10

// region codes as seen on req_code
`define FEED_CODE_CFG      4'd0
`define FEED_CODE_WEIADDR  4'd3
`define FEED_CODE_WEI      4'd4
`define FEED_CODE_FLGWEI   4'd5
`define FEED_CODE_ACT      4'd6
`define FEED_CODE_FLGACT   4'd7

// words per request
`define FEED_SIZE_CFG      64
`define FEED_SIZE_WEIADDR  54
`define FEED_SIZE_FLGWEI   512
`define FEED_SIZE_WEI      512
`define FEED_SIZE_FLGACT   512
`define FEED_SIZE_ACT      512

// blocks held by each region before the pointer wraps
`define FEED_BLOCKS_CFG      1
`define FEED_BLOCKS_WEIADDR  2
`define FEED_BLOCKS_FLGWEI   1
`define FEED_BLOCKS_WEI      2
`define FEED_BLOCKS_FLGACT   4
`define FEED_BLOCKS_ACT      9

// rom space per block, in words
`define FEED_STRIDE_CFG      64
`define FEED_STRIDE_WEIADDR  64
`define FEED_STRIDE_FLGWEI   512
`define FEED_STRIDE_WEI      512
`define FEED_STRIDE_FLGACT   512
`define FEED_STRIDE_ACT      512

// regions are packed back to back in this order
`define FEED_BASE_CFG      (0)
`define FEED_BASE_WEIADDR  (`FEED_BASE_CFG + `FEED_STRIDE_CFG * `FEED_BLOCKS_CFG)
`define FEED_BASE_FLGWEI   (`FEED_BASE_WEIADDR + `FEED_STRIDE_WEIADDR * `FEED_BLOCKS_WEIADDR)
`define FEED_BASE_WEI      (`FEED_BASE_FLGWEI + `FEED_STRIDE_FLGWEI * `FEED_BLOCKS_FLGWEI)
`define FEED_BASE_FLGACT   (`FEED_BASE_WEI + `FEED_STRIDE_WEI * `FEED_BLOCKS_WEI)
`define FEED_BASE_ACT      (`FEED_BASE_FLGACT + `FEED_STRIDE_FLGACT * `FEED_BLOCKS_FLGACT)

`endif

//--- source/xfer_pkg.sv
`include "feed_config.svh"

package xfer_pkg;

    // ========================================================================
    // transfer side types
    // ========================================================================

    // one of the six region codes
    typedef logic [`FEED_CODE_W-1:0] region_code_t;

    // read sizes and word positions inside a request
    typedef logic [`FEED_COUNT_W-1:0] word_count_t;

    // sequencer states
    typedef enum logic [1:0] {
        IDLE,    // waiting for a request
        LOAD,    // region table lookup, address counter loaded
        STREAM   // rom reads and output handshakes
    } seq_state_t;

endpackage

//--- source/mem_pkg.sv
`include "feed_config.svh"

package mem_pkg;

    // ========================================================================
    // pattern rom types
    // ========================================================================

    // word address into the rom
    typedef logic [`FEED_ADDR_W-1:0] rom_addr_t;

    // one 128-bit data word, four 32-bit lanes
    typedef logic [`FEED_DATA_W-1:0] rom_word_t;

endpackage

//--- source/xfer_sequencer.sv
`timescale 1ns/1ps

module xfer_sequencer
    import xfer_pkg::*;
    import mem_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    // request channel
    input  logic         req_valid,
    input  region_code_t req_code,
    output logic         req_ready,
    output logic         busy,
    // region table
    output region_code_t cur_code,
    input  rom_addr_t    start_addr,
    input  word_count_t  read_size,
    output logic         advance,
    // rom port
    output logic         rom_en,
    output rom_addr_t    rom_addr,
    input  rom_word_t    rom_data,
    // data channel
    output logic         out_valid,
    output rom_word_t    out_data,
    output logic         out_last,
    input  logic         out_ready
);

    seq_state_t  state;
    rom_addr_t   rd_addr;      // next rom address to read
    word_count_t issue_cnt;    // reads issued so far
    logic        rom_vld;      // rom output holds a word not yet taken
    logic        rom_last;     // that word is the final one
    logic        accept;
    logic        out_move;
    logic        stage_free;
    logic        load_out;
    logic        issue;

    assign req_ready  = (state == IDLE);
    assign busy       = (state != IDLE);
    assign accept     = req_valid && req_ready;
    assign out_move   = out_valid && out_ready;
    assign stage_free = !out_valid || out_ready;   // empty, or emptying now
    assign load_out   = rom_vld && stage_free;
    assign issue      = (state == STREAM) && (issue_cnt != read_size) && stage_free;
    assign advance    = (state == STREAM) && out_move && out_last;
    assign rom_en     = issue;
    assign rom_addr   = rd_addr;

    // ========================================================================
    // control FSM
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            cur_code <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state    <= LOAD;
                        cur_code <= req_code;
                    end
                end
                LOAD:    state <= STREAM;
                STREAM:  if (advance) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // address and read counters, start address only valid in LOAD
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_addr   <= '0;
            issue_cnt <= '0;
        end else if (state == LOAD) begin
            rd_addr   <= start_addr;
            issue_cnt <= '0;
        end else if (issue) begin
            rd_addr   <= rd_addr + rom_addr_t'(1);
            issue_cnt <= issue_cnt + word_count_t'(1);
        end
    end

    // rom keeps its output while en is low, so a stalled word waits there
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rom_vld  <= 1'b0;
            rom_last <= 1'b0;
        end else if (issue) begin
            rom_vld  <= 1'b1;
            rom_last <= (issue_cnt == read_size - word_count_t'(1));
        end else if (load_out) begin
            rom_vld  <= 1'b0;
        end
    end

    // ========================================================================
    // output stage
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else if (load_out) begin
            out_valid <= 1'b1;
            out_last  <= rom_last;
        end else if (out_move) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) out_data <= rom_data;   // held while stalled
    end

endmodule

//--- source/region_table.sv
`timescale 1ns/1ps
`include "feed_config.svh"

module region_table
    import xfer_pkg::*;
    import mem_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  region_code_t cur_code,
    input  logic         advance,    // last word of cur_code moved
    output rom_addr_t    start_addr,
    output word_count_t  read_size
);

    localparam int NUM_REGIONS = 6;

    // ========================================================================
    // region constants, index order cfg, weiaddr, flgwei, wei, flgact, act
    // ========================================================================
    localparam rom_addr_t REGION_BASE [NUM_REGIONS] = '{
        rom_addr_t'(`FEED_BASE_CFG),    rom_addr_t'(`FEED_BASE_WEIADDR),
        rom_addr_t'(`FEED_BASE_FLGWEI), rom_addr_t'(`FEED_BASE_WEI),
        rom_addr_t'(`FEED_BASE_FLGACT), rom_addr_t'(`FEED_BASE_ACT)
    };

    localparam rom_addr_t REGION_STRIDE [NUM_REGIONS] = '{
        rom_addr_t'(`FEED_STRIDE_CFG),    rom_addr_t'(`FEED_STRIDE_WEIADDR),
        rom_addr_t'(`FEED_STRIDE_FLGWEI), rom_addr_t'(`FEED_STRIDE_WEI),
        rom_addr_t'(`FEED_STRIDE_FLGACT), rom_addr_t'(`FEED_STRIDE_ACT)
    };

    // offset at which the pointer wraps back to 0
    localparam rom_addr_t REGION_SPAN [NUM_REGIONS] = '{
        rom_addr_t'(`FEED_STRIDE_CFG * `FEED_BLOCKS_CFG),
        rom_addr_t'(`FEED_STRIDE_WEIADDR * `FEED_BLOCKS_WEIADDR),
        rom_addr_t'(`FEED_STRIDE_FLGWEI * `FEED_BLOCKS_FLGWEI),
        rom_addr_t'(`FEED_STRIDE_WEI * `FEED_BLOCKS_WEI),
        rom_addr_t'(`FEED_STRIDE_FLGACT * `FEED_BLOCKS_FLGACT),
        rom_addr_t'(`FEED_STRIDE_ACT * `FEED_BLOCKS_ACT)
    };

    localparam word_count_t REGION_SIZE [NUM_REGIONS] = '{
        word_count_t'(`FEED_SIZE_CFG),    word_count_t'(`FEED_SIZE_WEIADDR),
        word_count_t'(`FEED_SIZE_FLGWEI), word_count_t'(`FEED_SIZE_WEI),
        word_count_t'(`FEED_SIZE_FLGACT), word_count_t'(`FEED_SIZE_ACT)
    };

    rom_addr_t  offset [NUM_REGIONS];   // current block offset per region
    logic [2:0] idx;
    rom_addr_t  next_offset;
    rom_addr_t  wrap_offset;

    // code to table index
    always_comb begin
        case (cur_code)
            `FEED_CODE_WEIADDR: idx = 3'd1;
            `FEED_CODE_FLGWEI:  idx = 3'd2;
            `FEED_CODE_WEI:     idx = 3'd3;
            `FEED_CODE_FLGACT:  idx = 3'd4;
            `FEED_CODE_ACT:     idx = 3'd5;
            default:            idx = 3'd0;   // cfg
        endcase
    end

    assign start_addr  = REGION_BASE[idx] + offset[idx];
    assign read_size   = REGION_SIZE[idx];
    assign next_offset = offset[idx] + REGION_STRIDE[idx];
    assign wrap_offset = (next_offset == REGION_SPAN[idx]) ? '0 : next_offset;

    // circular pointer advance
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGIONS; i++) offset[i] <= '0;
        end else if (advance) begin
            offset[idx] <= wrap_offset;
        end
    end

endmodule

//--- source/pattern_rom.sv
`timescale 1ns/1ps
`include "feed_config.svh"

module pattern_rom
    import mem_pkg::*;
(
    input  logic      clk,
    input  logic      en,
    input  rom_addr_t addr,
    output rom_word_t data
);

    rom_word_t mem [`FEED_ROM_DEPTH];

    // four lanes, each {c0de, lane number, word address}
    function automatic rom_word_t pattern_word(int unsigned a);
        rom_word_t w;
        for (int j = 0; j < 4; j++) begin
            w[j*32 +: 32] = {16'hC0DE, 2'(j), 14'(a)};
        end
        return w;
    endfunction

    initial begin
        for (int unsigned a = 0; a < `FEED_ROM_DEPTH; a++) begin
            mem[a] = pattern_word(a);
        end
    end

    // one cycle read latency, output holds while en is low
    always_ff @(posedge clk) begin
        if (en) begin
            data <= mem[addr];
        end
    end

endmodule

//--- source/data_feeder.sv
`timescale 1ns/1ps

module data_feeder
    import xfer_pkg::*;
    import mem_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         req_valid,
    input  region_code_t req_code,
    output logic         req_ready,
    output logic         busy,
    output logic         out_valid,
    output rom_word_t    out_data,
    output logic         out_last,
    input  logic         out_ready
);

    region_code_t cur_code;
    logic         advance;
    rom_addr_t    start_addr;
    word_count_t  read_size;
    logic         rom_en;
    rom_addr_t    rom_addr;
    rom_word_t    rom_data;

    xfer_sequencer u_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_code   (req_code),
        .req_ready  (req_ready),
        .busy       (busy),
        .cur_code   (cur_code),
        .start_addr (start_addr),
        .read_size  (read_size),
        .advance    (advance),
        .rom_en     (rom_en),
        .rom_addr   (rom_addr),
        .rom_data   (rom_data),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_last   (out_last),
        .out_ready  (out_ready)
    );

    region_table u_regions (
        .clk        (clk),
        .rst_n      (rst_n),
        .cur_code   (cur_code),
        .advance    (advance),
        .start_addr (start_addr),
        .read_size  (read_size)
    );

    pattern_rom u_rom (
        .clk  (clk),
        .en   (rom_en),
        .addr (rom_addr),
        .data (rom_data)
    );

endmodule

//--- bench/data_feeder_chk.sv
`timescale 1ns/1ps
`include "feed_config.svh"

module data_feeder_chk
    import xfer_pkg::*;
    import mem_pkg::*;
(
    input logic         clk,
    input logic         rst_n,
    input logic         req_valid,
    input region_code_t req_code,
    input logic         req_ready,
    input logic         busy,
    input logic         out_valid,
    input rom_word_t    out_data,
    input logic         out_last,
    input logic         out_ready
);

    int fail_count = 0;   // failed assertions so far

    // ========================================================================
    // handshake rules
    // ========================================================================
    legal_code: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |-> req_code inside {`FEED_CODE_CFG, `FEED_CODE_WEIADDR,
            `FEED_CODE_WEI, `FEED_CODE_FLGWEI, `FEED_CODE_ACT, `FEED_CODE_FLGACT})
    else begin
        fail_count++;
        $error("req_code %h is not a region code", req_code);
    end

    // stalled word stays put
    stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
    else begin
        fail_count++;
        $error("output word changed while stalled");
    end

    // idle means no transfer and no word on offer
    idle_excl: assert property (@(posedge clk) disable iff (!rst_n)
        req_ready |-> !busy && !out_valid)
    else begin
        fail_count++;
        $error("req_ready high while busy or while a word is offered");
    end

endmodule

//--- bench/data_feeder_tb.sv
`timescale 1ns/1ps
`include "feed_config.svh"

module data_feeder_tb
    import xfer_pkg::*;
    import mem_pkg::*;
();

    localparam int NUM_REQ   = 40;
    localparam int MAX_WORDS = 512;
    localparam int TIMEOUT   = NUM_REQ * MAX_WORDS * 4 + 1000;   // 4x for back-pressure

    // region order cfg, weiaddr, flgwei, wei, flgact, act
    localparam region_code_t CODES [6] = '{`FEED_CODE_CFG, `FEED_CODE_WEIADDR,
        `FEED_CODE_FLGWEI, `FEED_CODE_WEI, `FEED_CODE_FLGACT, `FEED_CODE_ACT};
    localparam int BASE [6] = '{`FEED_BASE_CFG, `FEED_BASE_WEIADDR, `FEED_BASE_FLGWEI,
        `FEED_BASE_WEI, `FEED_BASE_FLGACT, `FEED_BASE_ACT};
    localparam int STRIDE [6] = '{`FEED_STRIDE_CFG, `FEED_STRIDE_WEIADDR,
        `FEED_STRIDE_FLGWEI, `FEED_STRIDE_WEI, `FEED_STRIDE_FLGACT, `FEED_STRIDE_ACT};
    localparam int BLOCKS [6] = '{`FEED_BLOCKS_CFG, `FEED_BLOCKS_WEIADDR,
        `FEED_BLOCKS_FLGWEI, `FEED_BLOCKS_WEI, `FEED_BLOCKS_FLGACT, `FEED_BLOCKS_ACT};
    localparam int SIZE [6] = '{`FEED_SIZE_CFG, `FEED_SIZE_WEIADDR, `FEED_SIZE_FLGWEI,
        `FEED_SIZE_WEI, `FEED_SIZE_FLGACT, `FEED_SIZE_ACT};

    logic         clk;
    logic         rst_n;
    logic         req_valid;
    region_code_t req_code;
    logic         req_ready;
    logic         busy;
    logic         out_valid;
    rom_word_t    out_data;
    logic         out_last;
    logic         out_ready;

    logic [31:0]  rnd_state;
    int           model_offset [6];   // reference block offset per region
    int           errors = 0;
    int           words  = 0;
    int           cycles = 0;

    data_feeder u_data_feeder (.*);

    bind data_feeder data_feeder_chk u_chk (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_code  (req_code),
        .req_ready (req_ready),
        .busy      (busy),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_last  (out_last),
        .out_ready (out_ready)
    );

    // ========================================================================
    // reference model
    // ========================================================================
    function automatic logic [31:0] xorshift(logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rnd_state = xorshift(rnd_state);
        return rnd_state;
    endfunction

    function automatic int code_index(region_code_t code);
        case (code)
            `FEED_CODE_WEIADDR: return 1;
            `FEED_CODE_FLGWEI:  return 2;
            `FEED_CODE_WEI:     return 3;
            `FEED_CODE_FLGACT:  return 4;
            `FEED_CODE_ACT:     return 5;
            default:            return 0;
        endcase
    endfunction

    // marker, lane number, word address in each 32-bit lane
    function automatic rom_word_t expected_word(int unsigned addr);
        rom_word_t   w;
        logic [31:0] lane;
        for (int j = 0; j < 4; j++) begin
            lane = 32'hC0DE_0000 | (32'(j) << 14) | (addr & 32'h3FFF);
            w[j*32 +: 32] = lane;
        end
        return w;
    endfunction

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout after %0d cycles, the DUT stopped delivering words", cycles);
            $display("Test failed");
            $finish;
        end
    end

    task automatic apply_reset();
        rst_n     <= 1'b0;
        req_valid <= 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < 6; i++) model_offset[i] = 0;   // all pointers back to block 0
    endtask

    // one request; stop_at below the read size abandons it mid-stream
    task automatic run_request(region_code_t code, int stop_at);
        int        idx;
        int        size;
        int        addr;
        int        count;
        logic      done;
        rom_word_t exp_data;
        idx   = code_index(code);
        size  = SIZE[idx];
        addr  = BASE[idx] + model_offset[idx];
        count = 0;
        done  = 1'b0;
        req_valid <= 1'b1;
        req_code  <= code;
        do begin
            @(posedge clk);
        end while (!req_ready);
        req_valid <= 1'b0;
        while (!done) begin
            if (out_valid && out_ready) begin
                exp_data = expected_word(addr + count);
                assert (out_data === exp_data) else begin
                    $display("FAIL out_data word %0d exp %h got %h", count, exp_data, out_data);
                    errors++;
                end
                assert (out_last === (count == size - 1)) else begin
                    $display("FAIL out_last word %0d exp %h got %h", count,
                             (count == size - 1), out_last);
                    errors++;
                end
                assert (busy === 1'b1) else begin
                    $display("FAIL busy word %0d exp %h got %h", count, 1'b1, busy);
                    errors++;
                end
                count++;
                words++;
                done = out_last || (count == stop_at);
            end
            out_ready <= (next_rand() % 10) >= 3;   // low about 30 percent
            if (!done) @(posedge clk);
        end
        if (stop_at >= size) begin
            assert (count == size) else begin
                $display("request to code %0d ended after %0d words instead of %0d",
                         code, count, size);
                errors++;
            end
            model_offset[idx] += STRIDE[idx];
            if (model_offset[idx] == STRIDE[idx] * BLOCKS[idx]) model_offset[idx] = 0;
            @(posedge clk);
            assert (req_ready && !busy) else begin
                $display("DUT did not return to idle one cycle after the last word");
                errors++;
            end
        end
    endtask

    // ========================================================================
    // test sequence
    // ========================================================================
    initial begin
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_code  = '0;
        out_ready = 1'b0;
        rnd_state = 32'd36066;
        @(posedge clk);
        apply_reset();

        for (int i = 0; i < 12; i++) run_request(`FEED_CODE_ACT, MAX_WORDS);   // wraps after 9
        for (int i = 0; i < 3; i++) run_request(`FEED_CODE_WEIADDR, MAX_WORDS); // 0, 64, 0
        for (int i = 0; i < 21; i++) run_request(CODES[next_rand() % 6], MAX_WORDS);

        // second reset in the middle of a transfer
        run_request(`FEED_CODE_ACT, 20);
        apply_reset();
        assert (!out_valid && !busy && req_ready) else begin
            $display("DUT not idle after a reset during a transfer");
            errors++;
        end
        run_request(`FEED_CODE_ACT, MAX_WORDS);
        run_request(`FEED_CODE_WEIADDR, MAX_WORDS);
        run_request(`FEED_CODE_CFG, MAX_WORDS);

        repeat (2) @(posedge clk);
        $display("words checked %0d, testbench errors %0d, assertion errors %0d",
                 words, errors, u_data_feeder.u_chk.fail_count);
        if (errors == 0 && u_data_feeder.u_chk.fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+source
source/xfer_pkg.sv
source/mem_pkg.sv
source/xfer_sequencer.sv
source/region_table.sv
source/pattern_rom.sv
source/data_feeder.sv
bench/data_feeder_chk.sv
bench/data_feeder_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := data_feeder_tb
FLIST    := flist.f
OBJ_DIR  := obj_dir
SIM_ARGS := +verilator+error+limit+1000
LOG      := sim.log
PASS_MSG := Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
